//--- spi_ctrl_config.svh
`ifndef SPI_CTRL_CONFIG_SVH
`define SPI_CTRL_CONFIG_SVH

// command word: wr flag, 3-bit reg address, 8-bit data
`define SPI_CMD_W 12
`define SPI_RD_W 8

// clk cycles per sclk half period, 2 or more
`define SPI_CLK_DIV 4

// power of two
`define SPI_FIFO_DEPTH 4

// register byte offsets
`define SPI_REG_CMD 4'h0
`define SPI_REG_STATUS 4'h4
`define SPI_REG_RDATA 4'h8

`endif

//--- spi_ctrl_pkg.sv
`include "spi_ctrl_config.svh"

package spi_ctrl_pkg;

  typedef logic [`SPI_CMD_W-1:0] spi_cmd_t;  // one command word
  typedef logic [`SPI_RD_W-1:0] spi_byte_t;  // one received byte

  typedef logic [3:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // FINISH holds cs_n low after the last bit
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    RECV,
    FINISH
  } spi_state_e;

endpackage

//--- spi_axil_regs.sv
`timescale 1ns/1ns
`include "spi_ctrl_config.svh"

module spi_axil_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  spi_ctrl_pkg::axil_addr_t  awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  spi_ctrl_pkg::axil_data_t  wdata,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  spi_ctrl_pkg::axil_addr_t  araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output spi_ctrl_pkg::axil_data_t  rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  input  logic                      busy,
  input  spi_ctrl_pkg::spi_byte_t   head,
  input  logic                      not_empty,
  input  logic                      overflow,
  output spi_ctrl_pkg::spi_cmd_t    cmd,
  output logic                      cmd_valid,
  output logic                      pop,
  output logic                      ovf_clear
);
  import spi_ctrl_pkg::*;

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic       aw_is_cmd;
  logic       wr_stall;
  logic       wr_hs;
  logic       rd_hs;
  axil_data_t rd_mux;
  logic [1:0] rd_resp_mux;

  assign aw_is_cmd = (awaddr == `SPI_REG_CMD);
  assign wr_stall = aw_is_cmd && (busy || cmd_valid);  // engine still owns the last command
  assign wr_hs = awvalid && awready && wvalid && wready;
  assign rd_hs = arvalid && arready;

  // side effects land on the same edge the read data is captured
  assign pop = rd_hs && (araddr == `SPI_REG_RDATA);
  assign ovf_clear = rd_hs && (araddr == `SPI_REG_STATUS);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      bresp <= RESP_OKAY;
      cmd_valid <= 1'b0;
    end
    else
    begin
      cmd_valid <= wr_hs && aw_is_cmd;
      if (awready)
      begin
        awready <= 1'b0;  // single cycle
        wready <= 1'b0;
      end
      else if (awvalid && wvalid && !bvalid && !wr_stall)
      begin
        awready <= 1'b1;
        wready <= 1'b1;
      end
      if (wr_hs)
      begin
        bvalid <= 1'b1;
        bresp <= aw_is_cmd ? RESP_OKAY : RESP_SLVERR;
      end
      else if (bvalid && bready)
        bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_hs && aw_is_cmd)
      cmd <= wdata[`SPI_CMD_W-1:0];
  end

  always_comb
  begin
    rd_mux = '0;
    rd_resp_mux = RESP_OKAY;
    case (araddr)
      `SPI_REG_STATUS: rd_mux = axil_data_t'({overflow, not_empty, busy});
      `SPI_REG_RDATA:
      begin
        if (not_empty)
          rd_mux = axil_data_t'(head);  // empty fifo reads 0
      end
      default: rd_resp_mux = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      rdata <= '0;
      rresp <= RESP_OKAY;
    end
    else
    begin
      if (arready)
        arready <= 1'b0;
      else if (arvalid && !rvalid)
        arready <= 1'b1;
      if (rd_hs)
      begin
        rvalid <= 1'b1;
        rdata <= rd_mux;
        rresp <= rd_resp_mux;
      end
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

endmodule

//--- spi_shift_engine.sv
`timescale 1ns/1ns
`include "spi_ctrl_config.svh"

module spi_shift_engine (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_ctrl_pkg::spi_cmd_t   cmd,
  input  logic                     cmd_valid,
  output logic                     busy,
  output logic                     sclk,
  output logic                     cs_n,
  output logic                     mosi,
  input  logic                     miso,
  output spi_ctrl_pkg::spi_byte_t  rd_byte,
  output logic                     rd_valid
);
  import spi_ctrl_pkg::*;

  localparam int DW = $clog2(2 * `SPI_CLK_DIV);
  localparam int BW = $clog2(`SPI_CMD_W);
  localparam logic [DW-1:0] RISE_AT = DW'(`SPI_CLK_DIV - 1);
  localparam logic [DW-1:0] FALL_AT = DW'(2 * `SPI_CLK_DIV - 1);
  localparam logic [BW-1:0] CMD_LAST = BW'(`SPI_CMD_W - 1);
  localparam logic [BW-1:0] RD_LAST = BW'(`SPI_RD_W - 1);

  spi_state_e    state;
  logic [DW-1:0] div_cnt;
  logic [BW-1:0] bit_cnt;
  spi_cmd_t      tx_sr;
  spi_byte_t     rx_sr;
  logic          is_read;
  logic          bit_end;

  assign bit_end = (div_cnt == FALL_AT);
  assign busy = (state != IDLE);
  assign mosi = tx_sr[`SPI_CMD_W-1];  // msb first, zeros once the command is out
  assign rd_byte = rx_sr;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      tx_sr <= '0;
      is_read <= 1'b0;
      sclk <= 1'b0;
      cs_n <= 1'b1;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= 1'b0;
      case (state)
        IDLE:
        begin
          if (cmd_valid)
          begin
            state <= SEND;
            tx_sr <= cmd;
            is_read <= ~cmd[`SPI_CMD_W-1];  // bit 11 clear means read
            cs_n <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
          end
        end
        SEND:
        begin
          if (div_cnt == RISE_AT)
            sclk <= 1'b1;
          if (bit_end)
          begin
            sclk <= 1'b0;
            div_cnt <= '0;
            tx_sr <= {tx_sr[`SPI_CMD_W-2:0], 1'b0};
            if (bit_cnt == CMD_LAST)
            begin
              bit_cnt <= '0;
              state <= is_read ? RECV : FINISH;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        RECV:
        begin
          if (div_cnt == RISE_AT)
            sclk <= 1'b1;
          if (bit_end)
          begin
            sclk <= 1'b0;
            div_cnt <= '0;
            if (bit_cnt == RD_LAST)
            begin
              bit_cnt <= '0;
              state <= FINISH;
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        FINISH:
        begin
          // half a bit of cs_n hold
          if (div_cnt == RISE_AT)
          begin
            state <= IDLE;
            cs_n <= 1'b1;
            rd_valid <= is_read;
            div_cnt <= '0;
          end
          else
            div_cnt <= div_cnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // sample miso with the rising sclk
  always_ff @(posedge clk)
  begin
    if (state == RECV && div_cnt == RISE_AT)
      rx_sr <= {rx_sr[`SPI_RD_W-2:0], miso};
  end

endmodule

//--- spi_rd_fifo.sv
`timescale 1ns/1ns
`include "spi_ctrl_config.svh"

module spi_rd_fifo (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_ctrl_pkg::spi_byte_t  rd_byte,
  input  logic                     rd_valid,
  input  logic                     pop,
  input  logic                     ovf_clear,
  output spi_ctrl_pkg::spi_byte_t  head,
  output logic                     not_empty,
  output logic                     overflow
);
  import spi_ctrl_pkg::*;

  localparam int PW = $clog2(`SPI_FIFO_DEPTH);
  localparam logic [PW:0] FULL_CNT = (PW + 1)'(`SPI_FIFO_DEPTH);

  spi_byte_t     mem [`SPI_FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full = (count == FULL_CNT);
  assign not_empty = (count != '0);
  assign do_pop = pop && not_empty;  // pop on empty is ignored
  assign do_push = rd_valid && (!full || do_pop);
  assign head = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= rd_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // a new drop wins over a clear in the same cycle
      if (rd_valid && !do_push)
        overflow <= 1'b1;
      else if (ovf_clear)
        overflow <= 1'b0;
    end
  end

endmodule

//--- spi_ctrl_top.sv
`timescale 1ns/1ns

module spi_ctrl_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  spi_ctrl_pkg::axil_addr_t  awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  spi_ctrl_pkg::axil_data_t  wdata,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  spi_ctrl_pkg::axil_addr_t  araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output spi_ctrl_pkg::axil_data_t  rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  output logic                      sclk,
  output logic                      cs_n,
  output logic                      mosi,
  input  logic                      miso
);
  import spi_ctrl_pkg::*;

  spi_cmd_t  cmd;
  logic      cmd_valid;
  logic      busy;
  logic      pop;
  logic      ovf_clear;
  spi_byte_t head;
  logic      not_empty;
  logic      overflow;
  spi_byte_t rd_byte;
  logic      rd_valid;

  spi_axil_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .busy(busy), .head(head), .not_empty(not_empty), .overflow(overflow),
    .cmd(cmd), .cmd_valid(cmd_valid), .pop(pop), .ovf_clear(ovf_clear)
  );

  spi_shift_engine u_engine (
    .clk(clk), .rst_n(rst_n),
    .cmd(cmd), .cmd_valid(cmd_valid), .busy(busy),
    .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .rd_byte(rd_byte), .rd_valid(rd_valid)
  );

  spi_rd_fifo u_fifo (
    .clk(clk), .rst_n(rst_n),
    .rd_byte(rd_byte), .rd_valid(rd_valid),
    .pop(pop), .ovf_clear(ovf_clear),
    .head(head), .not_empty(not_empty), .overflow(overflow)
  );

endmodule

//--- spi_ctrl_sva.sv
`timescale 1ns/1ns

module spi_ctrl_sva (
  input logic clk,
  input logic rst_n,
  input logic sclk,
  input logic cs_n,
  input logic mosi,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  int fail_count = 0;

  // no clock edges outside a frame
  sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n) cs_n |-> !sclk)
  else
  begin
    $error("sclk high while cs_n is high");
    fail_count++;
  end

  mosi_stable: assert property (@(posedge clk) disable iff (!rst_n) sclk |-> $stable(mosi))
  else
  begin
    $error("mosi changed while sclk high");
    fail_count++;
  end

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
  else
  begin
    $error("bvalid dropped before bready");
    fail_count++;
  end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
  else
  begin
    $error("rvalid dropped before rready");
    fail_count++;
  end

endmodule

bind spi_ctrl_top spi_ctrl_sva u_sva (
  .clk(clk), .rst_n(rst_n), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
  .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
);

//--- spi_ctrl_checker.sv
`timescale 1ns/1ns
`include "spi_ctrl_config.svh"

module spi_ctrl_checker (
  input logic                     clk,
  input logic                     rst_n,
  input logic [1:0]               bresp,
  input logic                     bvalid,
  input logic                     bready,
  input spi_ctrl_pkg::axil_data_t rdata,
  input logic [1:0]               rresp,
  input logic                     rvalid,
  input logic                     rready,
  input logic                     sclk,
  input logic                     cs_n,
  input spi_ctrl_pkg::spi_cmd_t   model_cmd
);
  import spi_ctrl_pkg::*;

  axil_data_t r_data_q[$];
  logic [1:0] r_resp_q[$];
  string      r_label_q[$];
  logic [1:0] b_resp_q[$];
  int         b_frames_q[$];
  string      b_label_q[$];
  spi_cmd_t   frame_q[$];

  string cur_test = "none";
  int    test_checks = 0;
  int    test_errors = 0;
  int    tests_run = 0;
  int    checks = 0;
  int    errors = 0;
  int    frames_done = 0;  // completed cs_n windows
  int    edges = 0;
  logic  sclk_q = 1'b0;
  logic  cs_q = 1'b1;

  task automatic check_value(input string label, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    test_checks++;
    if (exp !== act)
    begin
      errors++;
      test_errors++;
      $display("Error in %s, %s: expected %0h, actual %0h", cur_test, label, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    checks++;
    test_checks++;
    errors++;
    test_errors++;
    $display("%s failed: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
  endtask

  task automatic expect_rdata(input string label, input axil_data_t data,
                              input logic [1:0] resp);
    r_label_q.push_back(label);
    r_data_q.push_back(data);
    r_resp_q.push_back(resp);
  endtask

  // frames that must have ended before bvalid shows up
  task automatic queue_bresp(input string label, input logic [1:0] resp,
                             input int min_frames);
    b_label_q.push_back(label);
    b_resp_q.push_back(resp);
    b_frames_q.push_back(min_frames);
  endtask

  task automatic push_frame(input spi_cmd_t cmd);
    frame_q.push_back(cmd);
  endtask

  task automatic check_read();
    string label;
    if (r_data_q.size() == 0)
      note_failure("read response arrived with nothing pending");
    else
    begin
      label = r_label_q.pop_front();
      check_value({label, " rdata"}, r_data_q.pop_front(), rdata);
      check_value({label, " rresp"}, r_resp_q.pop_front(), rresp);
    end
  endtask

  task automatic check_write();
    string label;
    int    min_frames;
    if (b_resp_q.size() == 0)
      note_failure("write response arrived with nothing pending");
    else
    begin
      label = b_label_q.pop_front();
      min_frames = b_frames_q.pop_front();
      check_value({label, " bresp"}, b_resp_q.pop_front(), bresp);
      if (frames_done < min_frames)
        note_failure("bvalid came while the previous SPI frame was still running");
    end
  endtask

  task automatic check_frame();
    spi_cmd_t exp_cmd;
    if (frame_q.size() == 0)
      note_failure("SPI frame seen with no command pending");
    else
    begin
      exp_cmd = frame_q.pop_front();
      // a read frame carries 8 more bits for the byte
      check_value("frame sclk edges",
                  exp_cmd[`SPI_CMD_W-1] ? `SPI_CMD_W : `SPI_CMD_W + `SPI_RD_W, edges);
      check_value("frame command", exp_cmd, model_cmd);
    end
    edges = 0;
    frames_done++;
  endtask

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (rvalid && rready)
        check_read();
      if (bvalid && bready)
        check_write();
      if (!cs_n && sclk && !sclk_q)
        edges++;
      if (cs_n && !cs_q)
        check_frame();
    end
    sclk_q = sclk;
    cs_q = cs_n;
  end

  task automatic final_report(input int assert_fails);
    cur_test = "end of run";
    if (r_data_q.size() != 0 || b_resp_q.size() != 0)
      note_failure("AXI responses never arrived");
    if (frame_q.size() != 0)
      note_failure("SPI frames never appeared");
    if (assert_fails != 0)
      note_failure($sformatf("%0d assertion failures on the SPI pins or AXI handshake",
                             assert_fails));
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
  endtask

endmodule

//--- tb_spi_ctrl.sv
`timescale 1ns/1ns
`include "spi_ctrl_config.svh"

module tb_spi_ctrl;
  import spi_ctrl_pkg::*;

  localparam int NUM_CMDS = 28;  // spi commands over all tests
  localparam int NUM_TESTS = 6;
  localparam int CYCLE_LIMIT = NUM_CMDS * 21 * 2 * `SPI_CLK_DIV + NUM_TESTS * 200;
  localparam logic [1:0] OKAY = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic       clk;
  logic       rst_n;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       miso;

  logic [15:0] lfsr_state = 16'd4598;
  spi_byte_t   shadow [8];
  int          frames_issued = 0;
  int          cycles = 0;

  // peripheral model state
  spi_byte_t   periph_regs [8];
  spi_cmd_t    model_cmd = '0;
  spi_byte_t   model_out = '0;
  int          model_bits = 0;

  spi_ctrl_top UUT (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso)
  );

  spi_ctrl_checker chk (
    .clk(clk), .rst_n(rst_n),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .sclk(sclk), .cs_n(cs_n), .model_cmd(model_cmd)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge cs_n)
    model_bits = 0;

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      if (model_bits < `SPI_CMD_W)
        model_cmd = {model_cmd[`SPI_CMD_W-2:0], mosi};
      model_bits++;
      if (model_bits == `SPI_CMD_W)
      begin
        if (model_cmd[11])
          periph_regs[model_cmd[10:8]] = model_cmd[7:0];
        else
          model_out = periph_regs[model_cmd[10:8]];
      end
    end
  end

  // read phase sends msb first
  always @(negedge sclk)
  begin
    if (!cs_n && !model_cmd[11] && model_bits >= `SPI_CMD_W &&
        model_bits < `SPI_CMD_W + `SPI_RD_W)
    begin
      miso = model_out[7];
      model_out = {model_out[6:0], 1'b0};
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Error: simulation hung, still running after %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 16'hB400;  // galois taps 16,14,13,11
    return n;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    int         i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      r = {r[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic flip_coin();
    logic [7:0] r;
    r = rand_bits(1);
    return r[0];
  endfunction

  function automatic spi_byte_t expected_read(input logic [2:0] addr);
    return shadow[addr];  // zero until written
  endfunction

  task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                           input logic [1:0] resp, input int min_frames, input string label);
    logic done;
    chk.queue_bresp(label, resp, min_frames);
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    do @(posedge clk); while (!(awready && wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      bready = flip_coin();  // random stalls
      @(posedge clk);
      done = bvalid && bready;
      @(negedge clk);
    end
    bready = 1'b0;
  endtask

  task automatic read_reg(input axil_addr_t addr, input axil_data_t data,
                          input logic [1:0] resp, input string label);
    logic done;
    chk.expect_rdata(label, data, resp);
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      rready = flip_coin();
      @(posedge clk);
      done = rvalid && rready;
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  // every earlier frame must be over before this bvalid
  task automatic send_cmd(input spi_cmd_t cmd);
    chk.push_frame(cmd);
    write_reg(`SPI_REG_CMD, axil_data_t'(cmd), OKAY, frames_issued, "cmd");
    frames_issued++;
  endtask

  task automatic store_byte(input logic [2:0] addr, input spi_byte_t data);
    send_cmd({1'b1, addr, data});
    shadow[addr] = data;
  endtask

  task automatic request_byte(input logic [2:0] addr);
    send_cmd({1'b0, addr, rand_bits(8)});  // data bits unused on a read
  endtask

  task automatic wait_frames();
    while (chk.frames_done < frames_issued)
      @(negedge clk);
  endtask

  task automatic read_back(input logic [2:0] addr);
    request_byte(addr);
    wait_frames();
    read_reg(`SPI_REG_RDATA, axil_data_t'(expected_read(addr)), OKAY, "rdata");
  endtask

  initial
  begin : main
    int         i;
    logic [2:0] a;
    logic [2:0] addrs [5];
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    miso = 1'b0;
    for (i = 0; i < 8; i++)
    begin
      shadow[i] = '0;
      periph_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    chk.start_test("reset_state");
    chk.check_value("cs_n", 1, cs_n);
    chk.check_value("sclk", 0, sclk);
    read_reg(`SPI_REG_STATUS, 0, OKAY, "status");
    chk.end_test();

    chk.start_test("write_read_back");
    a = 3'(rand_bits(3));  // random start then all 8 in turn
    for (i = 0; i < 8; i++)
      store_byte(a + 3'(i), rand_bits(8));
    for (i = 0; i < 8; i++)
      read_back(3'(rand_bits(3)));
    chk.end_test();

    chk.start_test("frame_shape");
    a = 3'(rand_bits(3));
    store_byte(a, rand_bits(8));
    read_back(a);
    chk.end_test();

    chk.start_test("back_pressure");
    a = 3'(rand_bits(3));
    store_byte(a, rand_bits(8));
    store_byte(a, rand_bits(8));  // issued while the first frame runs
    read_back(a);
    chk.end_test();

    chk.start_test("fifo_behavior");
    for (i = 0; i < 5; i++)
    begin
      addrs[i] = 3'(rand_bits(3));
      request_byte(addrs[i]);
    end
    wait_frames();
    read_reg(`SPI_REG_STATUS, 32'h6, OKAY, "status overflow");
    for (i = 0; i < 4; i++)
      read_reg(`SPI_REG_RDATA, axil_data_t'(expected_read(addrs[i])), OKAY, "rdata pop");
    read_reg(`SPI_REG_STATUS, 0, OKAY, "status drained");
    read_reg(`SPI_REG_RDATA, 0, OKAY, "rdata empty");
    chk.end_test();

    chk.start_test("error_responses");
    a = 3'(rand_bits(3));
    request_byte(a);
    wait_frames();
    write_reg(`SPI_REG_STATUS, axil_data_t'({1'b1, a, ~expected_read(a)}), SLVERR, 0,
              "status write");
    read_reg(4'hC, 0, SLVERR, "offset c");
    read_reg(`SPI_REG_RDATA, axil_data_t'(expected_read(a)), OKAY, "rdata kept");
    read_reg(`SPI_REG_STATUS, 0, OKAY, "status");
    read_back(a);  // peripheral register untouched
    chk.end_test();

    chk.final_report(UUT.u_sva.fail_count);
    if (chk.errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
spi_ctrl_pkg.sv
spi_axil_regs.sv
spi_shift_engine.sv
spi_rd_fifo.sv
spi_ctrl_top.sv
spi_ctrl_sva.sv
spi_ctrl_checker.sv
tb_spi_ctrl.sv

//--- Bender.yml
package:
  name: spi_ctrl

sources:
  - include_dirs:
      - .
    files:
      - spi_ctrl_pkg.sv
      - spi_axil_regs.sv
      - spi_shift_engine.sv
      - spi_rd_fifo.sv
      - spi_ctrl_top.sv
      - target: test
        files:
          - spi_ctrl_sva.sv
          - spi_ctrl_checker.sv
          - tb_spi_ctrl.sv
